/* build.f */
mem_pkg.sv
load_extract.sv
store_align.sv
mem_access_ctrl.sv
data_ram.sv
mem_subsys.sv
tb_clk_gen.sv
mem_subsys_props.sv
tb_mem_subsys.sv

/* data_ram.sv */
// Byte-masked doubleword data RAM with a fixed two-edge access latency and a one-cycle finish pulse
`timescale 1ns/100ps
`default_nettype none

module data_ram (
    input  wire                  clk_i,
    input  wire                  rst_n_i,
    input  wire                  re_i,
    input  wire                  we_i,
    input  wire mem_pkg::addr_t  addr_i,
    input  wire mem_pkg::data_t  wdata_i,
    input  wire mem_pkg::wmask_t wmask_i,
    output mem_pkg::data_t       rdata_o,
    output logic                 mem_finish_o
);

    mem_pkg::data_t             mem [mem_pkg::RAM_WORDS];
    logic [1:0]                 acc_cnt;   // 0 idle, 1 request seen, 2 finishing
    logic [mem_pkg::RAM_AW-1:0] word_idx;
    logic                       req;
    logic                       commit;

    assign req      = re_i | we_i;
    assign word_idx = addr_i[mem_pkg::RAM_AW+2:3];
    assign commit   = rst_n_i & req & (acc_cnt == 2'd1);   // Second edge of the request

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            acc_cnt <= 2'd0;
        end else begin
            case (acc_cnt)
                2'd0:    acc_cnt <= req ? 2'd1 : 2'd0;
                2'd1:    acc_cnt <= req ? 2'd2 : 2'd0;
                default: acc_cnt <= 2'd0;   // Upstream consumes the access in the finish cycle
            endcase
        end
    end

    assign mem_finish_o = (acc_cnt == 2'd2);

    always_ff @(posedge clk_i) begin
        if (commit && we_i) begin
            for (int b = 0; b < $bits(mem_pkg::wmask_t); b++) begin
                if (wmask_i[b]) begin
                    mem[word_idx][b*8 +: 8] <= wdata_i[b*8 +: 8];
                end
            end
        end
        if (commit && re_i) begin
            rdata_o <= mem[word_idx];
        end
    end

endmodule

`default_nettype wire

/* load_extract.sv */
// Load extractor that picks the addressed lane from a read doubleword and sign or zero extends it
`timescale 1ns/100ps
`default_nettype none

module load_extract (
    input  wire mem_pkg::data_t      rdata_i,
    input  wire [2:0]                addr_lo_i,
    input  wire mem_pkg::ls_sel_t    ls_sel_i,
    input  wire mem_pkg::inst_type_t inst_type_i,
    output mem_pkg::data_t           load_data_o
);

    logic [7:0]  pick_byte;
    logic [15:0] pick_half;
    logic [31:0] pick_word;

    always_comb begin
        case (addr_lo_i)
            3'd0:    pick_byte = rdata_i[7:0];
            3'd1:    pick_byte = rdata_i[15:8];
            3'd2:    pick_byte = rdata_i[23:16];
            3'd3:    pick_byte = rdata_i[31:24];
            3'd4:    pick_byte = rdata_i[39:32];
            3'd5:    pick_byte = rdata_i[47:40];
            3'd6:    pick_byte = rdata_i[55:48];
            default: pick_byte = rdata_i[63:56];
        endcase
    end

    always_comb begin
        case (addr_lo_i[2:1])
            2'd0:    pick_half = rdata_i[15:0];
            2'd1:    pick_half = rdata_i[31:16];
            2'd2:    pick_half = rdata_i[47:32];
            default: pick_half = rdata_i[63:48];
        endcase
    end

    assign pick_word = addr_lo_i[2] ? rdata_i[63:32] : rdata_i[31:0];

    always_comb begin
        load_data_o = '0;
        if (inst_type_i == mem_pkg::ITYPE_LOAD) begin
            case (ls_sel_i)
                mem_pkg::LB_SEL:  load_data_o = {{56{pick_byte[7]}}, pick_byte};
                mem_pkg::LH_SEL:  load_data_o = {{48{pick_half[15]}}, pick_half};
                mem_pkg::LW_SEL:  load_data_o = {{32{pick_word[31]}}, pick_word};
                mem_pkg::LD_SEL:  load_data_o = rdata_i;   // Whole doubleword
                mem_pkg::LBU_SEL: load_data_o = {56'd0, pick_byte};
                mem_pkg::LHU_SEL: load_data_o = {48'd0, pick_half};
                mem_pkg::LWU_SEL: load_data_o = {32'd0, pick_word};
                default:          load_data_o = '0;
            endcase
        end
    end

endmodule

`default_nettype wire

/* mem_access_ctrl.sv */
// Memory stage controller for RAM strobes, store data, writeback select and stall
`timescale 1ns/100ps
`default_nettype none

module mem_access_ctrl (
    input  wire                      rst_n_i,
    input  wire mem_pkg::inst_type_t inst_type_i,
    input  wire mem_pkg::addr_t      ls_addr_i,
    input  wire mem_pkg::data_t      rd_data_i,
    input  wire mem_pkg::data_t      load_data_i,
    input  wire mem_pkg::data_t      st_data_i,
    input  wire mem_pkg::wmask_t     st_mask_i,
    input  wire                      mem_finish_i,
    input  wire                      fence_i,
    input  wire mem_pkg::pc_t        mem_pc_i,
    input  wire mem_pkg::inst_t      mem_inst_i,

    output logic                     re_o,
    output logic                     we_o,
    output mem_pkg::addr_t           data_addr_o,
    output mem_pkg::data_t           wdata_o,
    output mem_pkg::wmask_t          wmask_o,
    output mem_pkg::data_t           rd_data_o,
    output mem_pkg::pc_t             mem_pc_o,
    output mem_pkg::inst_t           mem_inst_o,
    output logic                     fence_o,
    output logic                     mem_stall_o
);

    logic is_load;
    logic is_store;

    assign is_load  = inst_type_i[mem_pkg::ITYPE_LOAD_BIT];
    assign is_store = inst_type_i[mem_pkg::ITYPE_STORE_BIT];

    // Strobes are levels held for the whole access
    assign re_o = rst_n_i & is_load;
    assign we_o = rst_n_i & is_store;

    assign data_addr_o = rst_n_i ? ls_addr_i  : '0;
    assign mem_pc_o    = rst_n_i ? mem_pc_i   : '0;
    assign mem_inst_o  = rst_n_i ? mem_inst_i : '0;

    // Only a store puts data and lanes on the bus
    assign wdata_o = we_o ? st_data_i : '0;
    assign wmask_o = we_o ? st_mask_i : '0;

    assign rd_data_o = is_load ? load_data_i : rd_data_i;   // Load result replaces ALU value

    // Fence is only carried along and stalls for as long as it is held
    assign fence_o = fence_i;

    always_comb begin
        mem_stall_o = 1'b0;
        if (rst_n_i) begin
            mem_stall_o = ((re_o | we_o) & ~mem_finish_i) | fence_i;
        end
    end

endmodule

`default_nettype wire

/* mem_pkg.sv */
// Shared bus types, load/store select codes and RAM sizing that the memory stage references by scope
`default_nettype none

package mem_pkg;

    // Bus widths
    typedef logic [63:0] data_t;
    typedef logic [63:0] addr_t;
    typedef logic [63:0] pc_t;
    typedef logic [31:0] inst_t;
    typedef logic [4:0]  regaddr_t;
    typedef logic [7:0]  wmask_t;     // One bit per byte lane
    typedef logic [2:0]  ls_sel_t;
    typedef logic [7:0]  inst_type_t;

    // Load width selects with bit 2 marking the unsigned forms
    localparam ls_sel_t LB_SEL  = 3'd0;
    localparam ls_sel_t LH_SEL  = 3'd1;
    localparam ls_sel_t LW_SEL  = 3'd2;
    localparam ls_sel_t LD_SEL  = 3'd3;
    localparam ls_sel_t LBU_SEL = 3'd4;
    localparam ls_sel_t LHU_SEL = 3'd5;
    localparam ls_sel_t LWU_SEL = 3'd6;

    // Store width selects
    localparam ls_sel_t SB_SEL = 3'd0;
    localparam ls_sel_t SH_SEL = 3'd1;
    localparam ls_sel_t SW_SEL = 3'd2;
    localparam ls_sel_t SD_SEL = 3'd3;

    // Instruction type bits
    localparam int ITYPE_STORE_BIT = 0;
    localparam int ITYPE_LOAD_BIT  = 1;

    // The only type code that enables load extraction
    localparam inst_type_t ITYPE_LOAD = inst_type_t'(1 << ITYPE_LOAD_BIT);

    // Data RAM geometry with the word index in address bits 11:3
    localparam int RAM_WORDS = 512;
    localparam int RAM_AW    = $clog2(RAM_WORDS);

endpackage

`default_nettype wire

/* mem_subsys.sv */
// Memory stage top that joins load extractor, store aligner, access controller and data RAM
`timescale 1ns/100ps
`default_nettype none

module mem_subsys (
    input  wire                      clk_i,
    input  wire                      rst_n_i,

    input  wire mem_pkg::inst_type_t inst_type_i,
    input  wire mem_pkg::ls_sel_t    ls_sel_i,
    input  wire mem_pkg::addr_t      ls_addr_i,
    input  wire                      rd_ena_i,
    input  wire mem_pkg::data_t      rd_data_i,
    input  wire mem_pkg::regaddr_t   rd_addr_i,
    input  wire mem_pkg::pc_t        mem_pc_i,
    input  wire mem_pkg::inst_t      mem_inst_i,
    input  wire                      fence_i,

    output logic                     rd_ena_o,
    output mem_pkg::data_t           rd_data_o,
    output mem_pkg::regaddr_t        rd_addr_o,
    output mem_pkg::pc_t             mem_pc_o,
    output mem_pkg::inst_t           mem_inst_o,
    output logic                     fence_o,
    output logic                     mem_stall_o
);

    logic            re;
    logic            we;
    logic            mem_finish;
    mem_pkg::addr_t  data_addr;
    mem_pkg::data_t  wdata;
    mem_pkg::wmask_t wmask;
    mem_pkg::data_t  rdata;
    mem_pkg::data_t  load_data;
    mem_pkg::data_t  st_data;
    mem_pkg::wmask_t st_mask;

    // Writeback target needs no work in this stage
    assign rd_addr_o = rd_addr_i;
    assign rd_ena_o  = rd_ena_i;

    store_align i_store_align (
        .addr_lo_i (ls_addr_i[2:0]),
        .ls_sel_i  (ls_sel_i),
        .operand_i (rd_data_i),
        .wdata_o   (st_data),
        .wmask_o   (st_mask)
    );

    load_extract i_load_extract (
        .rdata_i     (rdata),
        .addr_lo_i   (ls_addr_i[2:0]),
        .ls_sel_i    (ls_sel_i),
        .inst_type_i (inst_type_i),
        .load_data_o (load_data)
    );

    mem_access_ctrl i_mem_access_ctrl (
        .rst_n_i      (rst_n_i),
        .inst_type_i  (inst_type_i),
        .ls_addr_i    (ls_addr_i),
        .rd_data_i    (rd_data_i),
        .load_data_i  (load_data),
        .st_data_i    (st_data),
        .st_mask_i    (st_mask),
        .mem_finish_i (mem_finish),
        .fence_i      (fence_i),
        .mem_pc_i     (mem_pc_i),
        .mem_inst_i   (mem_inst_i),
        .re_o         (re),
        .we_o         (we),
        .data_addr_o  (data_addr),
        .wdata_o      (wdata),
        .wmask_o      (wmask),
        .rd_data_o    (rd_data_o),
        .mem_pc_o     (mem_pc_o),
        .mem_inst_o   (mem_inst_o),
        .fence_o      (fence_o),
        .mem_stall_o  (mem_stall_o)
    );

    data_ram i_data_ram (
        .clk_i        (clk_i),
        .rst_n_i      (rst_n_i),
        .re_i         (re),
        .we_i         (we),
        .addr_i       (data_addr),
        .wdata_i      (wdata),
        .wmask_i      (wmask),
        .rdata_o      (rdata),
        .mem_finish_o (mem_finish)
    );

endmodule

`default_nettype wire

/* mem_subsys_props.sv */
// Concurrent checks on strobes, write mask, finish pulse and stall that are bound into mem_subsys
`timescale 1ns/100ps
`default_nettype none

module mem_subsys_props (
    input wire                  clk_i,
    input wire                  rst_n_i,
    input wire                  re_i,
    input wire                  we_i,
    input wire mem_pkg::wmask_t wmask_i,
    input wire                  mem_finish_i,
    input wire                  fence_i,
    input wire                  mem_stall_i
);

    // Sampled mid-cycle where inputs and RAM state have settled
    a_strobes_exclusive: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        !(re_i && we_i))
        else $error("re and we high in the same cycle");

    a_mask_needs_we: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        (wmask_i != '0) |-> we_i)
        else $error("write mask set without we");

    a_finish_one_cycle: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        mem_finish_i |=> !mem_finish_i)
        else $error("mem_finish longer than one cycle");

    a_stall_release: assert property (@(negedge clk_i) disable iff (!rst_n_i)
        $fell(mem_stall_i) |-> (mem_finish_i || $fell(fence_i)))
        else $error("stall dropped without mem_finish or fence release");

endmodule

`default_nettype wire

/* run_sim.sh */
#!/usr/bin/env bash
# Builds the memory stage testbench with Verilator, runs it and checks the log
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/100ps \
    --top-module tb_mem_subsys -f build.f -o sim_mem_subsys

./obj_dir/sim_mem_subsys | tee sim.log

if grep -q "TESTS FAILED" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
echo "Simulation finished without failures"

/* store_align.sv */
// Store aligner that moves the store operand into its byte lane and builds the matching write mask
`timescale 1ns/100ps
`default_nettype none

module store_align (
    input  wire [2:0]             addr_lo_i,
    input  wire mem_pkg::ls_sel_t ls_sel_i,
    input  wire mem_pkg::data_t   operand_i,
    output mem_pkg::data_t        wdata_o,
    output mem_pkg::wmask_t       wmask_o
);

    // Bit offsets of the lane for each width
    logic [5:0] byte_sh;
    logic [5:0] half_sh;
    logic [5:0] word_sh;

    // Byte offsets used for the mask
    logic [2:0] half_lane;
    logic [2:0] word_lane;

    assign byte_sh   = {addr_lo_i, 3'b000};
    assign half_sh   = {addr_lo_i[2:1], 4'b0000};
    assign word_sh   = {addr_lo_i[2], 5'b00000};
    assign half_lane = {addr_lo_i[2:1], 1'b0};
    assign word_lane = {addr_lo_i[2], 2'b00};

    always_comb begin
        case (ls_sel_i)
            mem_pkg::SB_SEL: begin
                wdata_o = mem_pkg::data_t'(operand_i[7:0]) << byte_sh;
                wmask_o = mem_pkg::wmask_t'(8'b0000_0001) << addr_lo_i;
            end
            mem_pkg::SH_SEL: begin
                wdata_o = mem_pkg::data_t'(operand_i[15:0]) << half_sh;
                wmask_o = mem_pkg::wmask_t'(8'b0000_0011) << half_lane;
            end
            mem_pkg::SW_SEL: begin
                wdata_o = mem_pkg::data_t'(operand_i[31:0]) << word_sh;
                wmask_o = mem_pkg::wmask_t'(8'b0000_1111) << word_lane;
            end
            mem_pkg::SD_SEL: begin
                wdata_o = operand_i;
                wmask_o = 8'hff;
            end
            default: begin
                // Unknown width writes nothing
                wdata_o = '0;
                wmask_o = '0;
            end
        endcase
    end

endmodule

`default_nettype wire

/* tb_clk_gen.sv */
// Testbench clock and reset source with a 100 ns clock and reset held low for the first 8 cycles
`timescale 1ns/100ps
`default_nettype none

module tb_clk_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int PERIOD_NS    = 100;
    localparam int RESET_CYCLES = 8;

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #10;   // Released like any other input
        rst_n_o = 1'b1;
    end

endmodule

`default_nettype wire

/* tb_mem_subsys.sv */
// Directed testbench of the memory stage with a mirror of the data RAM, built by run_sim.sh
`timescale 1ns/100ps
`default_nettype none

module tb_mem_subsys;

    localparam int REPS        = 4;   // Stores per width
    localparam int LOAD_WORDS  = 2;
    localparam int ACCESSES    = 3 + 4 * REPS * 3 + LOAD_WORDS * 30 + 8;
    localparam int WDOG_CYCLES = 8 + ACCESSES * 10;
    localparam mem_pkg::inst_type_t T_STORE =
        mem_pkg::inst_type_t'(1 << mem_pkg::ITYPE_STORE_BIT);
    localparam mem_pkg::inst_type_t T_ALU = 8'h04;   // Neither load nor store

    logic                clk;
    logic                rst_n;
    mem_pkg::inst_type_t inst_type;
    mem_pkg::ls_sel_t    ls_sel;
    mem_pkg::addr_t      ls_addr;
    logic                rd_ena;
    mem_pkg::data_t      rd_data;
    mem_pkg::regaddr_t   rd_addr;
    mem_pkg::pc_t        pc;
    mem_pkg::inst_t      inst;
    logic                fence;
    logic                wb_ena;
    mem_pkg::data_t      wb_data;
    mem_pkg::regaddr_t   wb_addr;
    mem_pkg::pc_t        wb_pc;
    mem_pkg::inst_t      wb_inst;
    logic                fence_out;
    logic                stall;
    mem_pkg::data_t      model [mem_pkg::RAM_WORDS];   // Mirror of the data RAM
    int                  errors;
    int                  checks;
    int                  tests;

    tb_clk_gen i_tb_clk_gen (.clk_o(clk), .rst_n_o(rst_n));

    mem_subsys i_mem_subsys (
        .clk_i(clk), .rst_n_i(rst_n), .inst_type_i(inst_type), .ls_sel_i(ls_sel),
        .ls_addr_i(ls_addr), .rd_ena_i(rd_ena), .rd_data_i(rd_data), .rd_addr_i(rd_addr),
        .mem_pc_i(pc), .mem_inst_i(inst), .fence_i(fence), .rd_ena_o(wb_ena),
        .rd_data_o(wb_data), .rd_addr_o(wb_addr), .mem_pc_o(wb_pc), .mem_inst_o(wb_inst),
        .fence_o(fence_out), .mem_stall_o(stall)
    );

    bind mem_subsys mem_subsys_props i_mem_subsys_props (
        .clk_i(clk_i), .rst_n_i(rst_n_i), .re_i(re), .we_i(we), .wmask_i(wmask),
        .mem_finish_i(mem_finish), .fence_i(fence_i), .mem_stall_i(mem_stall_o)
    );

    function automatic mem_pkg::data_t random_word();
        return {$urandom, $urandom};
    endfunction

    // Lane of the model word extended as the load select asks
    function automatic mem_pkg::data_t expected_load(mem_pkg::data_t word, int off, int sel);
        int             nbytes;
        mem_pkg::data_t v;
        nbytes = 1 << (sel % 4);
        v = word >> (off * 8);
        if (nbytes < 8) begin
            v = v & ((64'd1 << (nbytes * 8)) - 64'd1);
            if (sel < 4 && v[nbytes * 8 - 1]) begin
                v = v | ~((64'd1 << (nbytes * 8)) - 64'd1);
            end
        end
        return v;
    endfunction

    task automatic check_value(input string name, input mem_pkg::data_t got,
                               input mem_pkg::data_t exp);
        checks++;
        if (got !== exp) begin
            $display("ERROR %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic report(input string name, input int err_before);
        tests++;
        $display("test %s finished with %0d errors", name, errors - err_before);
    endtask

    task automatic next_slot();
        @(posedge clk);
        #10;
    endtask

    task automatic drive_op(input mem_pkg::inst_type_t t, input int sel,
                            input mem_pkg::addr_t a, input mem_pkg::data_t d);
        inst_type = t;
        ls_sel    = mem_pkg::ls_sel_t'(sel);
        ls_addr   = a;
        rd_data   = d;
        rd_addr   = mem_pkg::regaddr_t'($urandom);
        rd_ena    = 1'b1;
        pc        = {32'd0, $urandom};
        inst      = $urandom;
    endtask

    // Counts cycles with stall up and returns inside the finish cycle
    task automatic wait_release(output int n);
        n = 0;
        #1;
        while (stall === 1'b1) begin
            n++;
            @(posedge clk);
            #5;
        end
    endtask

    task automatic do_access(input mem_pkg::inst_type_t t, input int sel,
                             input mem_pkg::addr_t a, input mem_pkg::data_t d,
                             output mem_pkg::data_t res);
        int n;
        drive_op(t, sel, a, d);
        wait_release(n);
        check_value("mem_stall_o cycles", 64'(n), 64'd2);
        res = wb_data;
        next_slot();   // Access consumed at this edge
        inst_type = T_ALU;
    endtask

    task automatic store(input int sel, input int idx, input int off, input mem_pkg::data_t d);
        mem_pkg::data_t res;
        do_access(T_STORE, sel, mem_pkg::addr_t'(idx * 8 + off), d, res);
        for (int b = 0; b < (1 << sel); b++) begin
            model[idx][(off + b) * 8 +: 8] = d[b * 8 +: 8];
        end
    endtask

    task automatic test_reset_passthrough();
        int e0;
        int n;
        e0 = errors;
        repeat (3) @(posedge clk);
        #10;
        check_value("mem_pc_o", wb_pc, 64'd0);
        check_value("mem_inst_o", 64'(wb_inst), 64'd0);
        check_value("mem_stall_o", 64'(stall), 64'd0);
        inst_type = T_ALU;
        wait (rst_n === 1'b1);
        next_slot();
        drive_op(T_ALU, 0, random_word(), random_word());
        wait_release(n);
        check_value("mem_stall_o cycles", 64'(n), 64'd0);
        check_value("rd_data_o", wb_data, rd_data);
        check_value("rd_addr_o", 64'(wb_addr), 64'(rd_addr));
        check_value("rd_ena_o", 64'(wb_ena), 64'(rd_ena));
        check_value("mem_pc_o", wb_pc, pc);
        check_value("mem_inst_o", 64'(wb_inst), 64'(inst));
        rd_ena = 1'b0;
        #1;
        check_value("rd_ena_o", 64'(wb_ena), 64'd0);
        next_slot();
        report("reset_passthrough", e0);
    endtask

    task automatic test_stores();
        int             e0;
        int             idx;
        int             off;
        mem_pkg::data_t res;
        e0 = errors;
        for (int w = 0; w < 4; w++) begin
            for (int r = 0; r < REPS; r++) begin
                idx = int'($urandom % mem_pkg::RAM_WORDS);
                off = int'($urandom % 8) & ~((1 << w) - 1);
                store(3, idx, 0, random_word());
                store(w, idx, off, random_word());
                do_access(mem_pkg::ITYPE_LOAD, 3, mem_pkg::addr_t'(idx * 8), random_word(), res);
                check_value("rd_data_o", res, model[idx]);
            end
        end
        report("stores", e0);
    endtask

    task automatic test_loads();
        int             e0;
        int             idx;
        mem_pkg::data_t res;
        e0 = errors;
        for (int k = 0; k < LOAD_WORDS; k++) begin
            idx = int'($urandom % mem_pkg::RAM_WORDS);
            store(3, idx, 0, random_word());
            for (int sel = 0; sel < 7; sel++) begin
                for (int off = 0; off < 8; off += 1 << (sel % 4)) begin
                    do_access(mem_pkg::ITYPE_LOAD, sel, mem_pkg::addr_t'(idx * 8 + off),
                              random_word(), res);
                    check_value("rd_data_o", res, expected_load(model[idx], off, sel));
                end
            end
        end
        report("loads", e0);
    endtask

    task automatic test_stall_timing();
        int e0;
        int idx;
        e0 = errors;
        idx = int'($urandom % mem_pkg::RAM_WORDS);
        store(3, idx, 0, random_word());
        drive_op(mem_pkg::ITYPE_LOAD, 3, mem_pkg::addr_t'(idx * 8), random_word());
        #1;
        check_value("mem_stall_o", 64'(stall), 64'd1);
        @(posedge clk);
        #5;
        check_value("mem_stall_o", 64'(stall), 64'd1);
        @(posedge clk);
        #5;
        check_value("mem_stall_o", 64'(stall), 64'd0);
        check_value("rd_data_o", wb_data, model[idx]);
        next_slot();
        inst_type = T_ALU;
        report("stall_timing", e0);
    endtask

    task automatic test_fence();
        int e0;
        e0 = errors;
        inst_type = T_ALU;
        fence = 1'b1;
        for (int c = 0; c < 5; c++) begin
            #1;
            check_value("fence_o", 64'(fence_out), 64'd1);
            check_value("mem_stall_o", 64'(stall), 64'd1);
            check_value("re|we", 64'(i_mem_subsys.re | i_mem_subsys.we), 64'd0);
            next_slot();
        end
        fence = 1'b0;
        #1;
        check_value("fence_o", 64'(fence_out), 64'd0);
        check_value("mem_stall_o", 64'(stall), 64'd0);
        next_slot();
        report("fence", e0);
    endtask

    initial begin
        #(WDOG_CYCLES * 100);
        $display("Watchdog expired after %0d cycles, the tests did not finish", WDOG_CYCLES);
        $display("TESTS FAILED");
        $finish;
    end

    initial begin
        void'($urandom(32'haf10a465));
        errors = 0;
        checks = 0;
        tests = 0;
        inst_type = mem_pkg::ITYPE_LOAD;   // Strobes must stay off in reset
        ls_sel = '0;
        ls_addr = '0;
        rd_ena = 1'b0;
        rd_data = '0;
        rd_addr = '0;
        pc = 64'h1000;
        inst = 32'h0000_0013;
        fence = 1'b0;
        test_reset_passthrough();
        test_stores();
        test_loads();
        test_stall_timing();
        test_fence();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire
